/* Bender.yml */
package:
  name: read_path

sources:
  - files:
      - verilog/rw_pkg.sv
      - verilog/axi_pkg.sv
      - verilog/read_arbiter.sv
      - verilog/axi_read_master.sv
      - verilog/read_path_top.sv
  - target: test
    files:
      - testbench/axi_mem_model.sv
      - testbench/read_path_tb.sv

/* sources.f */
verilog/rw_pkg.sv
verilog/axi_pkg.sv
verilog/read_arbiter.sv
verilog/axi_read_master.sv
verilog/read_path_top.sv
testbench/axi_mem_model.sv
testbench/read_path_tb.sv

/* testbench/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model #(
    parameter integer SEED = 1  // start value for the latency draws
) (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              ar_valid_i,
    input  axi_pkg::axi_ar_t  ar_i,
    output logic              ar_ready_o,
    output logic              r_valid_o,
    output axi_pkg::axi_r_t   r_o,
    input  logic              r_ready_i
);

    import axi_pkg::*;

    integer  seed = SEED;
    int      ar_wait;  // cycles left before ar_ready
    int      r_wait;   // cycles left before r_valid
    logic    busy;     // ar taken, r not yet done
    axi_ar_t ar_q;

    // byte at address a is its low address byte xor 5a
    function automatic logic [7:0] pattern_byte(input logic [63:0] a);
        return a[7:0] ^ 8'h5a;
    endfunction

    // whole dword around the address, the master picks its lanes
    function automatic axi_r_t make_beat(input axi_ar_t ar);
        axi_r_t r;
        r.id   = ar.id;
        r.last = 1'b1;  // single beat only
        r.data = '0;
        if (ar.addr[31]) begin
            r.resp = slverr;  // error region, data stays zero
        end else begin
            r.resp = okay;
            for (int lane = 0; lane < 8; lane++) begin
                r.data[8*lane +: 8] = pattern_byte({ar.addr[63:3], lane[2:0]});
            end
        end
        return r;
    endfunction

    initial begin
        ar_ready_o = 1'b0;
        r_valid_o  = 1'b0;
        r_o        = '0;
    end

    always @(posedge clk) begin
        if (reset_i) begin
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            busy       <= 1'b0;
            ar_wait    <= 0;
            r_wait     <= 0;
        end else begin
            if (ar_ready_o && ar_valid_i) begin  // address handshake
                ar_ready_o <= 1'b0;
                ar_q       <= ar_i;
                busy       <= 1'b1;
                r_wait     <= $unsigned($random(seed)) % 4;
            end else if (ar_valid_i && !busy && !ar_ready_o) begin
                if (ar_wait == 0) begin
                    ar_ready_o <= 1'b1;
                    ar_wait    <= $unsigned($random(seed)) % 4;  // for the next ar
                end else begin
                    ar_wait <= ar_wait - 1;
                end
            end
            if (busy && !r_valid_o) begin
                if (r_wait == 0) begin
                    r_valid_o <= 1'b1;
                    r_o       <= make_beat(ar_q);  // held until r_ready
                end else begin
                    r_wait <= r_wait - 1;
                end
            end else if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                busy      <= 1'b0;
            end
        end
    end

endmodule

/* testbench/read_path_tb.sv */
`timescale 1ns/1ps

module read_path_tb;

    import rw_pkg::*;
    import axi_pkg::*;

    localparam int N_ITER = 190;               // random rounds, up to two requests each
    localparam int N_REQ  = 17 + 2 * N_ITER;   // directed ones included
    localparam int WDOG_NS = N_REQ * 40 * 10;  // 40 cycles of 10 ns per request

    logic clk;
    logic reset_i;
    logic mem_req_valid_i, mem_req_ready_o, mem_rsp_valid_o, mem_rsp_ready_i;
    logic if_req_valid_i, if_req_ready_o, if_rsp_valid_o, if_rsp_ready_i;
    rw_req_t mem_req_i, if_req_i, inflight;
    rw_rsp_t mem_rsp_o, if_rsp_o, prev_mem_rsp, prev_if_rsp;
    logic    ar_valid_o, ar_ready_i, r_valid_i, r_ready_o;
    axi_ar_t ar_o, prev_ar;
    axi_r_t  r_i;

    integer seed = 32'h7d68;
    int     errors = 0;
    int     n_done = 0;   // responses checked
    int     cycle = 0;
    logic   busy;         // some request accepted, response not yet taken
    logic   prev_mem_hold, prev_if_hold, prev_ar_hold;
    logic   mem_acc, if_acc;
    int     mem_cyc, if_cyc;

    assign mem_acc = mem_req_valid_i && mem_req_ready_o;
    assign if_acc  = if_req_valid_i && if_req_ready_o;

    read_path_top #(.AXI_ID(4'h9)) dut (.*);

    axi_mem_model #(.SEED(32'h7d68)) u_mem (
        .clk(clk), .reset_i(reset_i),
        .ar_valid_i(ar_valid_o), .ar_i(ar_o), .ar_ready_o(ar_ready_i),
        .r_valid_o(r_valid_i), .r_o(r_i), .r_ready_i(r_ready_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic report_mismatch(input string name, input logic [63:0] exp, got);
        errors++;
        $display("Mismatch %s expected %0h got %0h", name, exp, got);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("failure at cycle %0d: %s", cycle, what);
    endtask

    // memory rule, low address byte xor 5a
    function automatic logic [7:0] addressed_byte(input rw_addr_t a);
        return a[7:0] ^ 8'h5a;
    endfunction

    function automatic rw_rsp_t expected_rsp(input rw_req_t req);
        rw_rsp_t r;
        r.data = '0;
        r.err  = req.addr[31];  // error region gives zero data
        for (int i = 0; i < 8; i++) begin
            if (!r.err && i < (1 << req.size)) begin
                r.data[8*i +: 8] = addressed_byte(req.addr + i);
            end
        end
        return r;
    endfunction

    function automatic rw_req_t random_request();
        rw_req_t r;
        r.size = rw_size_e'($unsigned($random(seed)) % 4);
        r.addr = {$random(seed), $random(seed)};
        r.addr[31] = ($unsigned($random(seed)) % 8) == 0;  // error region now and then
        r.addr = r.addr & ~((64'd1 << r.size) - 64'd1);    // aligned to the size
        return r;
    endfunction

    // one full request and response on either port
    task automatic issue_request(input bit use_if, input rw_req_t req, output int acc_cycle);
        logic    done;
        rw_rsp_t got;
        rw_rsp_t exp;
        exp = expected_rsp(req);
        if (use_if) begin
            if_req_valid_i <= 1'b1;
            if_req_i       <= req;
        end else begin
            mem_req_valid_i <= 1'b1;
            mem_req_i       <= req;
        end
        done = 1'b0;
        while (!done) begin
            @(posedge clk);
            done = use_if ? if_acc : mem_acc;
        end
        acc_cycle = cycle;
        if (use_if) if_req_valid_i <= 1'b0;
        else mem_req_valid_i <= 1'b0;
        done = 1'b0;
        while (!done) begin
            if (use_if) if_rsp_ready_i <= ($unsigned($random(seed)) % 4) != 0;
            else mem_rsp_ready_i <= ($unsigned($random(seed)) % 4) != 0;
            @(posedge clk);
            done = use_if ? (if_rsp_valid_o && if_rsp_ready_i)
                          : (mem_rsp_valid_o && mem_rsp_ready_i);
            got  = use_if ? if_rsp_o : mem_rsp_o;
        end
        if (use_if) if_rsp_ready_i <= 1'b0;
        else mem_rsp_ready_i <= 1'b0;
        n_done++;
        assert (got.data == exp.data)
            else report_mismatch(use_if ? "if_rsp_o.data" : "mem_rsp_o.data", exp.data, got.data);
        assert (got.err == exp.err)
            else report_mismatch(use_if ? "if_rsp_o.err" : "mem_rsp_o.err", exp.err, got.err);
    endtask

    // protocol monitor, sampled on the edge where tb inputs are stable
    always @(posedge clk) begin
        if (reset_i) begin
            busy          <= 1'b0;
            prev_mem_hold <= 1'b0;
            prev_if_hold  <= 1'b0;
            prev_ar_hold  <= 1'b0;
        end else begin
            assert (!(mem_rsp_valid_o && if_rsp_valid_o))
                else report_failure("rsp_valid high on both ports");
            assert (!r_ready_o || busy)
                else report_failure("r_ready high with no request in flight");
            if (mem_acc || if_acc) begin
                assert (!busy && !(mem_acc && if_acc))
                    else report_failure("request accepted while the channel was owned");
                busy     <= 1'b1;
                inflight <= mem_acc ? mem_req_i : if_req_i;
            end
            if ((mem_rsp_valid_o && mem_rsp_ready_i) ||
                (if_rsp_valid_o && if_rsp_ready_i)) begin
                busy <= 1'b0;
            end
            if (ar_valid_o && ar_ready_i) begin  // fields of every ar
                assert (ar_o.id == 4'h9) else report_mismatch("ar_o.id", 4'h9, ar_o.id);
                assert (ar_o.len == 8'd0) else report_mismatch("ar_o.len", 0, ar_o.len);
                assert (ar_o.burst == incr) else report_mismatch("ar_o.burst", incr, ar_o.burst);
                assert (ar_o.addr == inflight.addr)
                    else report_mismatch("ar_o.addr", inflight.addr, ar_o.addr);
                assert (ar_o.size == {1'b0, inflight.size})
                    else report_mismatch("ar_o.size", inflight.size, ar_o.size);
            end
            // stalled payloads must not move
            if (prev_mem_hold) assert (mem_rsp_valid_o && mem_rsp_o == prev_mem_rsp)
                else report_failure("mem response changed while stalled");
            if (prev_if_hold) assert (if_rsp_valid_o && if_rsp_o == prev_if_rsp)
                else report_failure("if response changed while stalled");
            if (prev_ar_hold) assert (ar_valid_o && ar_o == prev_ar)
                else report_failure("ar changed while ar_ready was low");
            prev_mem_hold <= mem_rsp_valid_o && !mem_rsp_ready_i;
            prev_if_hold  <= if_rsp_valid_o && !if_rsp_ready_i;
            prev_ar_hold  <= ar_valid_o && !ar_ready_i;
            prev_mem_rsp  <= mem_rsp_o;
            prev_if_rsp   <= if_rsp_o;
            prev_ar       <= ar_o;
        end
    end

    initial begin
        rw_req_t req;
        int      mode;
        reset_i         = 1'b1;
        mem_req_valid_i = 1'b0;
        mem_req_i       = '0;
        mem_rsp_ready_i = 1'b0;
        if_req_valid_i  = 1'b0;
        if_req_i        = '0;
        if_rsp_ready_i  = 1'b0;
        repeat (2) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        // every size at every aligned offset
        for (int s = 0; s < 4; s++) begin
            for (int off = 0; off < 8; off += (1 << s)) begin
                req.size = rw_size_e'(s);
                req.addr = 64'h0000_00a5_1234_5670 + off;
                issue_request(1'b0, req, mem_cyc);
            end
        end
        req.size = size_word;
        req.addr = 64'h0000_0000_8000_0014;  // error region, one per port
        issue_request(1'b1, req, if_cyc);
        issue_request(1'b0, req, mem_cyc);
        for (int n = 0; n < N_ITER; n++) begin
            mode = $unsigned($random(seed)) % 3;
            if (mode == 2) begin  // both at once, mem must win
                fork
                    issue_request(1'b0, random_request(), mem_cyc);
                    issue_request(1'b1, random_request(), if_cyc);
                join
                assert (mem_cyc < if_cyc)
                    else report_failure("if request accepted ahead of mem request");
            end else begin
                issue_request(mode == 1, random_request(), mem_cyc);
            end
            repeat ($unsigned($random(seed)) % 3) @(posedge clk);  // idle gap
        end
        repeat (4) @(posedge clk);
        $display("responses checked %0d, errors %0d", n_done, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(WDOG_NS);
        report_failure("watchdog expired before all requests completed");
        $display("responses checked %0d, errors %0d", n_done, errors);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* verilog/axi_pkg.sv */
package axi_pkg;

    // axi read channel widths
    localparam int unsigned AXI_ID_W   = 4;
    localparam int unsigned AXI_ADDR_W = 64;
    localparam int unsigned AXI_DATA_W = 64;

    typedef logic [AXI_ID_W-1:0]   axi_id_t;
    typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
    typedef logic [AXI_DATA_W-1:0] axi_data_t;
    typedef logic [7:0]            axi_len_t;   // beats minus one
    typedef logic [2:0]            axi_size_t;  // log2 bytes per beat

    // burst type encoding
    typedef enum logic [1:0] {
        fixed = 2'b00,
        incr  = 2'b01,
        wrap  = 2'b10
    } axi_burst_e;

    // read response encoding
    typedef enum logic [1:0] {
        okay   = 2'b00,
        exokay = 2'b01,
        slverr = 2'b10,  // slave reported an error
        decerr = 2'b11   // no slave at this address
    } axi_resp_e;

    // read address channel payload
    typedef struct packed {
        axi_id_t    id;
        axi_addr_t  addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_e burst;
    } axi_ar_t;

    // read data channel payload
    typedef struct packed {
        axi_id_t   id;
        axi_data_t data;
        axi_resp_e resp;
        logic      last;  // final beat of the burst
    } axi_r_t;

endpackage

/* verilog/axi_read_master.sv */
`timescale 1ns/1ps

module axi_read_master #(
    parameter axi_pkg::axi_id_t AXI_ID = 4'h0  // id put on every ar
) (
    input  logic              clk,
    input  logic              reset_i,

    // requester side, from the arbiter
    input  logic              req_valid_i,
    input  rw_pkg::rw_req_t   req_i,
    output logic              req_ready_o,
    output logic              rsp_valid_o,
    output rw_pkg::rw_rsp_t   rsp_o,
    input  logic              rsp_ready_i,

    // axi read address channel
    output logic              ar_valid_o,
    output axi_pkg::axi_ar_t  ar_o,
    input  logic              ar_ready_i,

    // axi read data channel
    input  logic              r_valid_i,
    input  axi_pkg::axi_r_t   r_i,
    output logic              r_ready_o
);

    import rw_pkg::*;
    import axi_pkg::*;

    typedef enum logic [1:0] {
        st_idle = 2'd0,  // waiting for a request
        st_addr = 2'd1,  // ar_valid up
        st_data = 2'd2,  // r_ready up
        st_resp = 2'd3   // rsp_valid up
    } state_e;

    state_e   state_q;
    state_e   state_d;

    rw_req_t  req_q;       // latched request, held for the whole transaction
    rw_rsp_t  rsp_q;       // registered response, stable under back pressure
    logic [5:0] shamt;     // bit offset of the first addressed byte
    rw_data_t beat_shift;  // beat moved down to bit 0
    rw_data_t beat_align;  // masked to the access size

    // fsm next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            st_idle: if (req_valid_i) state_d = st_addr;
            st_addr: if (ar_ready_i)  state_d = st_data;
            st_data: if (r_valid_i)   state_d = st_resp;
            st_resp: if (rsp_ready_i) state_d = st_idle;
            default: state_d = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= st_idle;
        end else begin
            state_q <= state_d;
        end
    end

    // handshake outputs straight from state
    assign req_ready_o = (state_q == st_idle);
    assign ar_valid_o  = (state_q == st_addr);
    assign r_ready_o   = (state_q == st_data);
    assign rsp_valid_o = (state_q == st_resp);

    // single beat read, size follows the request
    always_comb begin
        ar_o       = '0;
        ar_o.id    = AXI_ID;
        ar_o.addr  = req_q.addr;
        ar_o.len   = 8'd0;               // one beat
        ar_o.size  = {1'b0, req_q.size}; // same log2 encoding
        ar_o.burst = incr;
    end

    // byte lane extraction
    assign shamt      = {req_q.addr[2:0], 3'b000};
    assign beat_shift = r_i.data >> shamt;

    always_comb begin
        case (req_q.size)
            size_byte:  beat_align = {56'd0, beat_shift[7:0]};
            size_half:  beat_align = {48'd0, beat_shift[15:0]};
            size_word:  beat_align = {32'd0, beat_shift[31:0]};
            default:    beat_align = beat_shift;  // full dword
        endcase
    end

    // payload regs
    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            req_q <= req_i;  // capture at the request transfer
        end
        if (r_valid_i && r_ready_o) begin
            rsp_q.data <= beat_align;
            rsp_q.err  <= (r_i.resp != okay);  // slverr, decerr, exokay all count
        end
    end

    assign rsp_o = rsp_q;

endmodule

/* verilog/read_arbiter.sv */
`timescale 1ns/1ps

module read_arbiter (
    input  logic              clk,
    input  logic              reset_i,

    // load unit port
    input  logic              mem_req_valid_i,
    input  rw_pkg::rw_req_t   mem_req_i,
    output logic              mem_req_ready_o,
    output logic              mem_rsp_valid_o,
    output rw_pkg::rw_rsp_t   mem_rsp_o,
    input  logic              mem_rsp_ready_i,

    // instruction fetch port
    input  logic              if_req_valid_i,
    input  rw_pkg::rw_req_t   if_req_i,
    output logic              if_req_ready_o,
    output logic              if_rsp_valid_o,
    output rw_pkg::rw_rsp_t   if_rsp_o,
    input  logic              if_rsp_ready_i,

    // toward the read master
    output logic              out_req_valid_o,
    output rw_pkg::rw_req_t   out_req_o,
    input  logic              out_req_ready_i,
    input  logic              out_rsp_valid_i,
    input  rw_pkg::rw_rsp_t   out_rsp_i,
    output logic              out_rsp_ready_o
);

    import rw_pkg::*;

    grant_e grant_q;  // current owner
    grant_e grant_d;
    logic   rsp_done; // owner takes its response this cycle

    assign rsp_done = out_rsp_valid_i && out_rsp_ready_o;

    // fixed priority, mem first
    // grant is locked until the owner's response transfers
    always_comb begin
        grant_d = grant_q;
        case (grant_q)
            grant_none: begin
                if (mem_req_valid_i) begin
                    grant_d = grant_mem;
                end else if (if_req_valid_i) begin
                    grant_d = grant_if;
                end
            end
            grant_mem, grant_if: begin
                if (rsp_done) begin
                    grant_d = grant_none;  // one idle cycle before the next grant
                end
            end
            default: grant_d = grant_none;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            grant_q <= grant_none;
        end else begin
            grant_q <= grant_d;
        end
    end

    // request and response muxing, all steered by the registered grant
    always_comb begin
        out_req_valid_o = 1'b0;
        out_req_o       = mem_req_i;  // don't care while not granted
        out_rsp_ready_o = 1'b0;
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        if_req_ready_o  = 1'b0;
        if_rsp_valid_o  = 1'b0;
        case (grant_q)
            grant_mem: begin
                out_req_valid_o = mem_req_valid_i;
                out_req_o       = mem_req_i;
                out_rsp_ready_o = mem_rsp_ready_i;
                mem_req_ready_o = out_req_ready_i;
                mem_rsp_valid_o = out_rsp_valid_i;
            end
            grant_if: begin
                out_req_valid_o = if_req_valid_i;
                out_req_o       = if_req_i;
                out_rsp_ready_o = if_rsp_ready_i;
                if_req_ready_o  = out_req_ready_i;
                if_rsp_valid_o  = out_rsp_valid_i;
            end
            default: ;  // nobody owns the channel
        endcase
    end

    // payload fans out to both, qualified by rsp_valid
    assign mem_rsp_o = out_rsp_i;
    assign if_rsp_o  = out_rsp_i;

endmodule

/* verilog/read_path_top.sv */
`timescale 1ns/1ps

module read_path_top #(
    parameter axi_pkg::axi_id_t AXI_ID = 4'h0
) (
    input  logic              clk,
    input  logic              reset_i,

    // load unit
    input  logic              mem_req_valid_i,
    input  rw_pkg::rw_req_t   mem_req_i,
    output logic              mem_req_ready_o,
    output logic              mem_rsp_valid_o,
    output rw_pkg::rw_rsp_t   mem_rsp_o,
    input  logic              mem_rsp_ready_i,

    // instruction fetch
    input  logic              if_req_valid_i,
    input  rw_pkg::rw_req_t   if_req_i,
    output logic              if_req_ready_o,
    output logic              if_rsp_valid_o,
    output rw_pkg::rw_rsp_t   if_rsp_o,
    input  logic              if_rsp_ready_i,

    // axi read master port
    output logic              ar_valid_o,
    output axi_pkg::axi_ar_t  ar_o,
    input  logic              ar_ready_i,
    input  logic              r_valid_i,
    input  axi_pkg::axi_r_t   r_i,
    output logic              r_ready_o
);

    import rw_pkg::*;

    // arbiter to master link
    logic    arb_req_valid;
    rw_req_t arb_req;
    logic    arb_req_ready;
    logic    arb_rsp_valid;
    rw_rsp_t arb_rsp;
    logic    arb_rsp_ready;

    read_arbiter u_arb (
        .clk             (clk),
        .reset_i         (reset_i),
        .mem_req_valid_i (mem_req_valid_i),
        .mem_req_i       (mem_req_i),
        .mem_req_ready_o (mem_req_ready_o),
        .mem_rsp_valid_o (mem_rsp_valid_o),
        .mem_rsp_o       (mem_rsp_o),
        .mem_rsp_ready_i (mem_rsp_ready_i),
        .if_req_valid_i  (if_req_valid_i),
        .if_req_i        (if_req_i),
        .if_req_ready_o  (if_req_ready_o),
        .if_rsp_valid_o  (if_rsp_valid_o),
        .if_rsp_o        (if_rsp_o),
        .if_rsp_ready_i  (if_rsp_ready_i),
        .out_req_valid_o (arb_req_valid),
        .out_req_o       (arb_req),
        .out_req_ready_i (arb_req_ready),
        .out_rsp_valid_i (arb_rsp_valid),
        .out_rsp_i       (arb_rsp),
        .out_rsp_ready_o (arb_rsp_ready)
    );

    axi_read_master #(
        .AXI_ID (AXI_ID)  // transaction id from the top
    ) u_master (
        .clk         (clk),
        .reset_i     (reset_i),
        .req_valid_i (arb_req_valid),
        .req_i       (arb_req),
        .req_ready_o (arb_req_ready),
        .rsp_valid_o (arb_rsp_valid),
        .rsp_o       (arb_rsp),
        .rsp_ready_i (arb_rsp_ready),
        .ar_valid_o  (ar_valid_o),
        .ar_o        (ar_o),
        .ar_ready_i  (ar_ready_i),
        .r_valid_i   (r_valid_i),
        .r_i         (r_i),
        .r_ready_o   (r_ready_o)
    );

endmodule

/* verilog/rw_pkg.sv */
package rw_pkg;

    // requester side bus widths, fixed for the 64-bit core
    localparam int unsigned RW_ADDR_W = 64;
    localparam int unsigned RW_DATA_W = 64;

    // access size, value is log2 of the byte count
    typedef enum logic [1:0] {
        size_byte  = 2'd0,  // 1 byte
        size_half  = 2'd1,  // 2 bytes
        size_word  = 2'd2,  // 4 bytes
        size_dword = 2'd3   // 8 bytes
    } rw_size_e;

    typedef logic [RW_ADDR_W-1:0] rw_addr_t;  // byte address
    typedef logic [RW_DATA_W-1:0] rw_data_t;  // one data word

    // request phase payload
    // held stable by the requester until valid && ready
    typedef struct packed {
        rw_addr_t addr;  // byte address, any alignment within the dword
        rw_size_e size;  // bytes to fetch
    } rw_req_t;

    // response phase payload
    typedef struct packed {
        rw_data_t data;  // addressed bytes, zero extended
        logic     err;   // any non okay bus response
    } rw_rsp_t;

    // which requester currently owns the read channel
    typedef enum logic [1:0] {
        grant_none = 2'd0,  // channel free
        grant_mem  = 2'd1,  // load unit
        grant_if   = 2'd2   // instruction fetch
    } grant_e;

endpackage
